// File: batchFilter_defines.svh
`ifndef BATCHFILTER_DEFINES_SVH
`define BATCHFILTER_DEFINES_SVH

// Samples per batch, one pass covers a whole bank
`define BATCH_DEPTH 8

// Signed input sample width
`define SAMPLE_WIDTH 12

// Two guard bits keep the forward plus backward sum exact
`define OUT_WIDTH (`SAMPLE_WIDTH + 2)

// Feedback coefficient is 2**-COEF_SHIFT
`define COEF_SHIFT 1

`endif

// File: batchFilter_pkg.sv
`default_nettype none
`include "batchFilter_defines.svh"

package batchFilter_pkg;

    // Input sample
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Recursion state and combined sum
    typedef logic signed [`OUT_WIDTH-1:0] acc_t;

    // Index within one batch
    typedef logic [$clog2(`BATCH_DEPTH)-1:0] addr_t;

    // Processing FSM states
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        BACKWARD,
        FINISH
    } seqState_t;

    // Pass that a returned sample belongs to
    typedef enum logic {
        PASS_FWD,
        PASS_BWD
    } pass_t;

endpackage

`default_nettype wire

// File: recursionUnit.sv
`timescale 1ns/100ps
`default_nettype none
`include "batchFilter_defines.svh"

module recursionUnit (
    input  wire logic                     clkDS,
    input  wire logic                     rst,
    input  wire logic                     clear,
    input  wire logic                     step,
    input  wire batchFilter_pkg::sample_t x,
    output batchFilter_pkg::acc_t         state
);
    import batchFilter_pkg::*;

    // Value of the previous step
    acc_t acc;

    // State for the sample on x, valid in the cycle step is high
    // Power of two coefficient, so a shift replaces the multiplier
    assign state = x + (acc >>> `COEF_SHIFT);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            acc <= '0;
        end else if (clear) begin
            // Zero start for a new pass
            acc <= '0;
        end else if (step) begin
            acc <= state;
        end
    end

endmodule

`default_nettype wire

// File: sampleCollector.sv
`timescale 1ns/100ps
`default_nettype none
`include "batchFilter_defines.svh"

module sampleCollector (
    input  wire logic                     clkDS,
    input  wire logic                     rst,
    input  wire batchFilter_pkg::sample_t inSample,
    input  wire logic                     inValid,
    output logic                          inReady,
    output logic [1:0]                    bankFull,
    input  wire logic                     bankRelease,
    input  wire logic                     bankSel,
    input  wire logic                     rdBank,
    input  wire batchFilter_pkg::addr_t   rdAddr,
    output batchFilter_pkg::sample_t      rdData
);
    import batchFilter_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(`BATCH_DEPTH - 1);

    // Ping-pong sample banks
    sample_t mem [2][`BATCH_DEPTH];

    logic  fillBank;
    addr_t fillPtr;
    logic  wrEn;

    // Stall only when the bank being filled still waits for the sequencer
    assign inReady = !bankFull[fillBank];
    assign wrEn    = inValid && inReady;

    always_ff @(posedge clkDS) begin
        if (wrEn) begin
            mem[fillBank][fillPtr] <= inSample;
        end
        // Registered read port
        rdData <= mem[rdBank][rdAddr];
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fillBank <= 1'b0;
            fillPtr  <= '0;
            bankFull <= 2'b00;
        end else begin
            if (bankRelease) begin
                bankFull[bankSel] <= 1'b0;
            end
            if (wrEn) begin
                if (fillPtr == LAST_ADDR) begin
                    // Bank complete, hand it over and swap
                    fillPtr            <= '0;
                    fillBank           <= ~fillBank;
                    bankFull[fillBank] <= 1'b1;
                end else begin
                    fillPtr <= fillPtr + 1'b1;
                end
            end
        end
    end

    // A partly filled bank is never flagged full nor freed by the sequencer
    assert property (@(posedge clkDS) disable iff (!rst)
        fillPtr != '0 |-> !bankFull[fillBank] && !(bankRelease && bankSel == fillBank))
        else $error("sample write into a bank held by the sequencer");

endmodule

`default_nettype wire

// File: batchSequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "batchFilter_defines.svh"

module batchSequencer (
    input  wire logic                     clkDS,
    input  wire logic                     rst,
    input  wire logic [1:0]               bankFull,
    output logic                          bankRelease,
    output logic                          bankSel,
    output logic                          rdBank,
    output batchFilter_pkg::addr_t        rdAddr,
    input  wire batchFilter_pkg::sample_t rdData,
    input  wire logic [1:0]               resSpace,
    output logic                          resWrite,
    output logic                          resBankSel,
    output batchFilter_pkg::addr_t        resAddr,
    output logic [`OUT_WIDTH-1:0]         resData,
    output logic                          resCommit
);
    import batchFilter_pkg::*;

    localparam int CNT_W = $clog2(`BATCH_DEPTH + 1);
    // Each pass takes BATCH_DEPTH reads plus one cycle of read latency
    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`BATCH_DEPTH);

    seqState_t        seqState;
    logic [CNT_W-1:0] cnt;
    pass_t            curPass;
    pass_t            passD;
    logic             rdIssue;
    logic             rdValidD;
    addr_t            addrD;
    logic             fwdClear;
    logic             bwdClear;
    logic             fwdStep;
    logic             bwdStep;
    acc_t             fwdState;
    acc_t             bwdState;
    acc_t             sum;

    // Forward results per sample index
    acc_t partMem [`BATCH_DEPTH];

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            seqState   <= IDLE;
            cnt        <= '0;
            bankSel    <= 1'b0;
            resBankSel <= 1'b0;
            rdValidD   <= 1'b0;
        end else begin
            rdValidD <= rdIssue;
            case (seqState)
                IDLE: begin
                    // Need a full batch and an empty result bank
                    if (bankFull[bankSel] && resSpace[resBankSel]) begin
                        seqState <= FORWARD;
                    end
                end
                FORWARD: begin
                    if (cnt == LAST_CYCLE) begin
                        cnt      <= '0;
                        seqState <= BACKWARD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                BACKWARD: begin
                    if (cnt == LAST_CYCLE) begin
                        cnt      <= '0;
                        seqState <= FINISH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                FINISH: begin
                    seqState   <= IDLE;
                    bankSel    <= ~bankSel;
                    resBankSel <= ~resBankSel;
                end
                default: seqState <= IDLE;
            endcase
        end
    end

    // Read side, ascending forward and descending backward
    assign rdIssue = (seqState == FORWARD || seqState == BACKWARD) && cnt < LAST_CYCLE;
    assign rdAddr  = (seqState == BACKWARD) ? addr_t'(`BATCH_DEPTH - 1 - cnt) : addr_t'(cnt);
    assign rdBank  = bankSel;
    assign curPass = (seqState == BACKWARD) ? PASS_BWD : PASS_FWD;

    // Address and pass follow the read data by one cycle
    always_ff @(posedge clkDS) begin
        addrD <= rdAddr;
        passD <= curPass;
        if (fwdStep) begin
            partMem[addrD] <= fwdState;
        end
    end

    assign fwdClear = (seqState == IDLE);
    assign bwdClear = (seqState == FORWARD);
    assign fwdStep  = rdValidD && passD == PASS_FWD;
    assign bwdStep  = rdValidD && passD == PASS_BWD;

    recursionUnit fwdRec (
        .clkDS(clkDS),
        .rst  (rst),
        .clear(fwdClear),
        .step (fwdStep),
        .x    (rdData),
        .state(fwdState)
    );

    recursionUnit bwdRec (
        .clkDS(clkDS),
        .rst  (rst),
        .clear(bwdClear),
        .step (bwdStep),
        .x    (rdData),
        .state(bwdState)
    );

    // Combine with the stored forward value, offset binary out
    assign sum         = bwdState + partMem[addrD];
    assign resData     = {~sum[`OUT_WIDTH-1], sum[`OUT_WIDTH-2:0]};
    assign resWrite    = bwdStep;
    assign resAddr     = addrD;
    assign bankRelease = (seqState == FINISH);
    assign resCommit   = (seqState == FINISH);

    assert property (@(posedge clkDS) disable iff (!rst) resWrite |-> seqState == BACKWARD)
        else $error("result write outside the backward pass");

endmodule

`default_nettype wire

// File: resultStreamer.sv
`timescale 1ns/100ps
`default_nettype none
`include "batchFilter_defines.svh"

module resultStreamer (
    input  wire logic                    clkDS,
    input  wire logic                    rst,
    input  wire logic                    resWrite,
    input  wire logic                    resBankSel,
    input  wire batchFilter_pkg::addr_t  resAddr,
    input  wire logic [`OUT_WIDTH-1:0]   resData,
    input  wire logic                    resCommit,
    output logic [1:0]                   resSpace,
    output logic [`OUT_WIDTH-1:0]        outSample,
    output logic                         outValid,
    input  wire logic                    outReady
);
    import batchFilter_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(`BATCH_DEPTH - 1);

    // Ping-pong result banks
    logic [`OUT_WIDTH-1:0] mem [2][`BATCH_DEPTH];

    logic [1:0] committed;
    logic       drainBank;
    addr_t      drainPtr;
    logic       xfer;

    always_ff @(posedge clkDS) begin
        if (resWrite) begin
            mem[resBankSel][resAddr] <= resData;
        end
    end

    // Banks commit alternately, so the drain bank simply alternates too
    assign outValid  = committed[drainBank];
    assign outSample = mem[drainBank][drainPtr];
    assign resSpace  = ~committed;
    assign xfer      = outValid && outReady;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            committed <= 2'b00;
            drainBank <= 1'b0;
            drainPtr  <= '0;
        end else begin
            if (resCommit) begin
                committed[resBankSel] <= 1'b1;
            end
            if (xfer) begin
                if (drainPtr == LAST_ADDR) begin
                    // Last word gone, bank is free again
                    drainPtr             <= '0;
                    drainBank            <= ~drainBank;
                    committed[drainBank] <= 1'b0;
                end else begin
                    drainPtr <= drainPtr + 1'b1;
                end
            end
        end
    end

    // Held word must not change while the sink stalls
    assert property (@(posedge clkDS) disable iff (!rst)
        outValid && !outReady |=> outValid && $stable(outSample))
        else $error("output word changed under back-pressure");

endmodule

`default_nettype wire

// File: batchFilter.sv
`timescale 1ns/100ps
`default_nettype none
`include "batchFilter_defines.svh"

module batchFilter (
    input  wire logic                     clkDS,
    input  wire logic                     rst,
    input  wire batchFilter_pkg::sample_t inSample,
    input  wire logic                     inValid,
    output wire logic                     inReady,
    output wire logic [`OUT_WIDTH-1:0]    outSample,
    output wire logic                     outValid,
    input  wire logic                     outReady
);
    import batchFilter_pkg::*;

    // Collector to sequencer
    wire logic [1:0]  bankFull;
    wire logic        bankRelease;
    wire logic        bankSel;
    wire logic        rdBank;
    wire addr_t       rdAddr;
    wire sample_t     rdData;

    // Sequencer to streamer
    wire logic [1:0]            resSpace;
    wire logic                  resWrite;
    wire logic                  resBankSel;
    wire addr_t                 resAddr;
    wire logic [`OUT_WIDTH-1:0] resData;
    wire logic                  resCommit;

    sampleCollector collector (
        .clkDS      (clkDS),
        .rst        (rst),
        .inSample   (inSample),
        .inValid    (inValid),
        .inReady    (inReady),
        .bankFull   (bankFull),
        .bankRelease(bankRelease),
        .bankSel    (bankSel),
        .rdBank     (rdBank),
        .rdAddr     (rdAddr),
        .rdData     (rdData)
    );

    batchSequencer sequencer (
        .clkDS      (clkDS),
        .rst        (rst),
        .bankFull   (bankFull),
        .bankRelease(bankRelease),
        .bankSel    (bankSel),
        .rdBank     (rdBank),
        .rdAddr     (rdAddr),
        .rdData     (rdData),
        .resSpace   (resSpace),
        .resWrite   (resWrite),
        .resBankSel (resBankSel),
        .resAddr    (resAddr),
        .resData    (resData),
        .resCommit  (resCommit)
    );

    resultStreamer streamer (
        .clkDS     (clkDS),
        .rst       (rst),
        .resWrite  (resWrite),
        .resBankSel(resBankSel),
        .resAddr   (resAddr),
        .resData   (resData),
        .resCommit (resCommit),
        .resSpace  (resSpace),
        .outSample (outSample),
        .outValid  (outValid),
        .outReady  (outReady)
    );

endmodule

`default_nettype wire

// File: batchFilter_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "batchFilter_defines.svh"

module batchFilter_tb;
    import batchFilter_pkg::*;

    localparam int N = `BATCH_DEPTH;
    localparam int WAIT_LIMIT = 4000;

    typedef logic [`OUT_WIDTH-1:0] word_t;

    logic    clkDS;
    logic    rst;
    sample_t inSample;
    logic    inValid;
    logic    inReady;
    word_t   outSample;
    logic    outValid;
    logic    outReady;

    // Expected output words in stream order
    word_t   expQ[$];
    word_t   expWord;
    sample_t batch [N];
    string   testName;
    int      errors;
    int      errAtStart;
    int      testsRun;
    int      testsFailed;
    logic    stallMode;
    int      stallLeft;
    logic    readyHold;
    logic    sawInStall;

    batchFilter dut (
        .clkDS    (clkDS),
        .rst      (rst),
        .inSample (inSample),
        .inValid  (inValid),
        .inReady  (inReady),
        .outSample(outSample),
        .outValid (outValid),
        .outReady (outReady)
    );

    initial begin
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    // Forward and backward recursions from zero, summed and sign flipped
    function automatic void refBatch(input sample_t x [N], output word_t y [N]);
        int f [N];
        int fwd;
        int bwd;
        int i;
        fwd = 0;
        for (i = 0; i < N; i++) begin
            fwd  = int'(x[i]) + (fwd >>> `COEF_SHIFT);
            f[i] = fwd;
        end
        bwd = 0;
        for (i = N - 1; i >= 0; i--) begin
            bwd  = int'(x[i]) + (bwd >>> `COEF_SHIFT);
            // Offset binary
            y[i] = word_t'(f[i] + bwd) ^ (word_t'(1) << (`OUT_WIDTH - 1));
        end
    endfunction

    task automatic finishRun();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic timeoutStop(input string what);
        $display("Timeout: wait for %s expired in test %s", what, testName);
        errors++;
        finishRun();
    endtask

    task automatic startTest(input string name);
        testName   = name;
        errAtStart = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors > errAtStart) begin
            testsFailed++;
            $display("FAIL: %s (%0d errors)", testName, errors - errAtStart);
        end else begin
            $display("PASS: %s", testName);
        end
    endtask

    task automatic randomBatch();
        int i;
        for (i = 0; i < N; i++) begin
            batch[i] = sample_t'($urandom);
        end
    endtask

    // Sends count samples of batch, a full batch also queues its expected words
    task automatic sendBatch(input logic gaps, input int count);
        word_t y [N];
        int    i;
        int    n;
        logic  accepted;
        if (count == N) begin
            refBatch(batch, y);
            for (i = 0; i < N; i++) begin
                expQ.push_back(y[i]);
            end
        end
        for (i = 0; i < count; i++) begin
            accepted = 1'b0;
            n = 0;
            while (!accepted) begin
                @(negedge clkDS);
                inSample = batch[i];
                inValid  = gaps ? ($urandom_range(0, 1) == 1) : 1'b1;
                if (inValid && !inReady) begin
                    sawInStall = 1'b1;
                end
                // inReady only moves after a rising edge
                accepted = inValid && inReady;
                n++;
                if (n > WAIT_LIMIT) begin
                    timeoutStop("input handshake");
                end
            end
        end
    endtask

    task automatic waitDrain();
        int n;
        @(negedge clkDS);
        inValid = 1'b0;
        n = 0;
        while (expQ.size() != 0) begin
            @(posedge clkDS);
            n++;
            if (n > WAIT_LIMIT) begin
                timeoutStop("output drain");
            end
        end
        // Quiet window so stray words show up in this test
        repeat (2 * N + 8) @(posedge clkDS);
    endtask

    // Compare every output transfer against the queue
    always @(posedge clkDS) begin
        if (rst && outValid && outReady) begin
            if (expQ.size() == 0) begin
                $display("Unexpected output word %h in test %s", outSample, testName);
                errors++;
            end else begin
                expWord = expQ.pop_front();
                if (outSample !== expWord) begin
                    $display("** Error %s: expected %h, actual %h", testName, expWord, outSample);
                    errors++;
                end
            end
        end
    end

    // Sink side, long random stalls when enabled
    always @(negedge clkDS) begin
        if (!stallMode) begin
            outReady = 1'b1;
        end else begin
            outReady = readyHold;
            if (stallLeft > 0) begin
                stallLeft--;
            end else begin
                readyHold = ($urandom_range(0, 3) == 0);
                stallLeft = $urandom_range(5, 40);
            end
        end
    end

    initial begin
        int k;
        int i;
        int n;
        void'($urandom(32'h98720af2));
        rst         = 1'b0;
        inSample    = '0;
        inValid     = 1'b0;
        outReady    = 1'b1;
        stallMode   = 1'b0;
        stallLeft   = 0;
        readyHold   = 1'b1;
        sawInStall  = 1'b0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        testName    = "reset";
        repeat (3) @(posedge clkDS);
        @(negedge clkDS);
        rst = 1'b1;

        startTest("impulse");
        for (i = 0; i < N; i++) begin
            batch[i] = '0;
        end
        batch[0] = sample_t'(100);
        sendBatch(1'b0, N);
        waitDrain();
        endTest();

        startTest("random batches");
        for (k = 0; k < 10; k++) begin
            randomBatch();
            sendBatch(1'b0, N);
        end
        waitDrain();
        endTest();

        startTest("output back-pressure");
        @(posedge clkDS);
        sawInStall = 1'b0;
        readyHold  = 1'b0;
        stallLeft  = 120;
        stallMode  = 1'b1;
        for (k = 0; k < 6; k++) begin
            randomBatch();
            sendBatch(1'b0, N);
        end
        waitDrain();
        stallMode = 1'b0;
        if (!sawInStall) begin
            $display("inReady never dropped under output back-pressure in test %s", testName);
            errors++;
        end
        endTest();

        startTest("input gaps");
        // Same data gapless and then gapped
        for (k = 0; k < 3; k++) begin
            randomBatch();
            sendBatch(1'b0, N);
            sendBatch(1'b1, N);
        end
        waitDrain();
        endTest();

        startTest("extremes");
        for (i = 0; i < N; i++) begin
            batch[i] = sample_t'((1 << (`SAMPLE_WIDTH - 1)) - 1);
        end
        sendBatch(1'b0, N);
        for (i = 0; i < N; i++) begin
            batch[i] = sample_t'(-(1 << (`SAMPLE_WIDTH - 1)));
        end
        sendBatch(1'b0, N);
        waitDrain();
        endTest();

        startTest("reset mid-run");
        // Held sink lets results and full sample banks pile up first
        readyHold = 1'b0;
        stallLeft = WAIT_LIMIT;
        stallMode = 1'b1;
        for (k = 0; k < 3; k++) begin
            randomBatch();
            sendBatch(1'b0, N);
        end
        randomBatch();
        sendBatch(1'b0, 5);
        @(negedge clkDS);
        inValid = 1'b0;
        n = 0;
        while (outValid !== 1'b1) begin
            @(negedge clkDS);
            n++;
            if (n > WAIT_LIMIT) begin
                timeoutStop("held output");
            end
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge clkDS);
            if (outValid !== 1'b0 || inReady !== 1'b1) begin
                $display("Wrong handshake during reset: outValid=%b inReady=%b", outValid, inReady);
                errors++;
            end
        end
        // Words queued before the reset are gone for good
        @(posedge clkDS);
        stallMode = 1'b0;
        expQ.delete();
        @(negedge clkDS);
        rst = 1'b1;
        randomBatch();
        sendBatch(1'b0, N);
        waitDrain();
        endTest();

        finishRun();
    end

endmodule

`default_nettype wire

// File: batchFilter.f
+incdir+.
batchFilter_pkg.sv
recursionUnit.sv
sampleCollector.sv
batchSequencer.sv
resultStreamer.sv
batchFilter.sv
batchFilter_tb.sv
